// File: bench/merge_trace.txt
# C test merge_mask ops_mask stall | P test lane_valid lane0 lane1 lane2 lane3 | E test packet
# Packets in hex: meta byte, then fields 3 down to 0, 16 bits each
C 1 f 8468 0
P 1 f 101013101210111010 111113111211111110 121213121212111210 131313131213111310
P 1 f 201023102210211020 211123112211211120 221223122212211220 231323132213211320
P 1 f 301033103210311030 311133113211311130 321233123212311230 331333133213311330
E 1 101310121011101010
E 1 201320122011201020
E 1 301330123011301030
C 2 5 4280 0
P 2 f 102013201220112010 112113211221112110 122213221222112210 132313231223112310
P 2 f 202023202220212020 212123212221212120 222223222222212220 232323232223212320
E 2 102013201222102010
E 2 202023202222202020
C 3 f 3010 1
P 3 f 103013301230113010 113113311231113110 123213321232113210 133313331233113310
P 3 f 203023302230213020 213123312231213120 223223322232213220 233323332233213320
P 3 f 303033303230313030 313133313231313130 323233323232313230 333333333233313330
E 3 103013301233103310
E 3 203023302233203320
E 3 303033303233303330

// File: verilog.f
logic/merge_packet_pkg.sv
logic/merge_ctrl_pkg.sv
logic/merge_links_if.sv
logic/lane_fifo.sv
logic/merge_fsm.sv
logic/field_merger.sv
logic/merge_data_generator.sv
bench/merge_checker.sv
bench/tb_merge_data_generator.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the merge data generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_merge_data_generator -o sim_merge
./obj_dir/sim_merge > sim.log
cat sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
echo "Simulation did not report success, see sim.log"
exit 1

// File: bench/tb_merge_data_generator.sv
// Testbench for the merge data generator
// Replays the trace file test by test with reset, setup handshake, lane
// packets and configuration, then waits for the merged output and done.
// Output stalls come from an LFSR

`timescale 1ns/1ps

module tb_merge_data_generator;
    import merge_packet_pkg::*;

    localparam int wait_limit = 400;
    localparam int done_limit = 100;

    logic                                      ap_clk = 1'b0;
    logic                                      areset;
    logic                                      cfg_request;
    logic                                      cfg_valid;
    merge_config_t                             cfg_data;
    logic [num_lanes-1:0]                      lane_valid;
    logic [num_lanes-1:0][meta_w-1:0]          lane_meta;
    logic [num_lanes-1:0][num_fields-1:0][field_w-1:0] lane_fields;
    logic [num_lanes-1:0]                      lane_full;
    logic                                      out_ready = 1'b1;
    logic                                      out_valid;
    logic [meta_w-1:0]                         out_meta;
    logic [num_fields-1:0][field_w-1:0]        out_fields;
    logic                                      config_setup;
    logic                                      done_out;

    logic        exp_push;
    packet_t     exp_pkt;
    logic        test_end;
    int          test_num;
    int          err_count;
    int          pending;
    int          run_failures;
    logic        stall_mode;
    int          stall_cnt = 0;
    logic [31:0] lfsr      = 32'hb5a0;

    // Trace contents with configurations indexed by test number
    logic [num_lanes-1:0]            cfg_mask  [16];
    logic [num_lanes*num_fields-1:0] cfg_ops   [16];
    logic                            cfg_stall [16];
    int                              test_list [$];
    int                              set_test  [$];
    logic [num_lanes-1:0]            set_valid [$];
    packet_t [num_lanes-1:0]         set_pkts  [$];
    int                              exp_test  [$];
    packet_t                         exp_list  [$];

    always #20 ap_clk = ~ap_clk;

    merge_data_generator DUT (
        .ap_clk      (ap_clk),
        .areset      (areset),
        .cfg_request (cfg_request),
        .cfg_valid   (cfg_valid),
        .cfg_data    (cfg_data),
        .lane_valid  (lane_valid),
        .lane_meta   (lane_meta),
        .lane_fields (lane_fields),
        .lane_full   (lane_full),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_meta    (out_meta),
        .out_fields  (out_fields),
        .config_setup(config_setup),
        .done_out    (done_out)
    );

    merge_checker u_check (
        .ap_clk      (ap_clk),
        .areset      (areset),
        .cfg_valid   (cfg_valid),
        .config_setup(config_setup),
        .done_out    (done_out),
        .lane_full   (lane_full),
        .out_valid   (out_valid),
        .out_meta    (out_meta),
        .out_fields  (out_fields),
        .exp_push    (exp_push),
        .exp_pkt     (exp_pkt),
        .test_end    (test_end),
        .test_num    (test_num),
        .err_count   (err_count),
        .pending     (pending)
    );

    // Galois LFSR with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // ------------------------------------------------------------
    // Output stalls of 40 held cycles and then one LFSR bit per cycle
    // ------------------------------------------------------------
    always @(posedge ap_clk) begin
        #2;
        if (!stall_mode) begin
            stall_cnt = 0;
            out_ready = 1'b1;
        end else if (stall_cnt < 40) begin
            stall_cnt++;
            out_ready = 1'b0;
        end else begin
            out_ready = lfsr[0];
            lfsr      = lfsr_next(lfsr);
        end
    end

    task automatic to_drive_point();
        @(posedge ap_clk);
        #2;
    endtask

    task automatic report_timeout(input string what, input int t, input int limit);
        $display("Timeout in test %0d: no %s within %0d cycles", t, what, limit);
        run_failures++;
    endtask

    task automatic read_trace();
        int          fd;
        int          n;
        int          t;
        string       line;
        byte         kind;
        logic [71:0] a, b, c, d, e;
        fd = $fopen("bench/merge_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file bench/merge_trace.txt");
            run_failures++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %d %h %h %h %h %h", kind, t, a, b, c, d, e);
                case (kind)
                    "C": begin
                        test_list.push_back(t);
                        cfg_mask[t]  = a[num_lanes-1:0];
                        cfg_ops[t]   = b[num_lanes*num_fields-1:0];
                        cfg_stall[t] = c[0];
                    end
                    "P": begin
                        set_test.push_back(t);
                        set_valid.push_back(a[num_lanes-1:0]);
                        set_pkts.push_back({e, d, c, b});
                    end
                    "E": begin
                        exp_test.push_back(t);
                        exp_list.push_back(a);
                    end
                    default: ;
                endcase
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // One test runs reset, setup, packets, configuration and drain
    // ------------------------------------------------------------
    task automatic run_test(input int t);
        int                      cnt;
        packet_t [num_lanes-1:0] lanes;
        areset = 1'b1;
        repeat (10) to_drive_point();
        areset      = 1'b0;
        test_num    = t;
        cfg_request = 1'b1;
        cnt = 0;
        do begin
            @(posedge ap_clk);
            cnt++;
        end while (!config_setup && cnt < wait_limit);
        if (!config_setup) report_timeout("config_setup pulse", t, wait_limit);
        #2;
        cfg_request = 1'b0;
        for (int k = 0; k < exp_list.size(); k++) begin
            if (exp_test[k] == t) begin
                exp_push = 1'b1;
                exp_pkt  = exp_list[k];
                to_drive_point();
            end
        end
        exp_push = 1'b0;
        // Packets go in before the configuration so nothing may leave yet
        for (int k = 0; k < set_pkts.size(); k++) begin
            if (set_test[k] == t) begin
                lanes      = set_pkts[k];
                lane_valid = set_valid[k];
                for (int i = 0; i < num_lanes; i++) begin
                    lane_meta[i]   = lanes[i].meta;
                    lane_fields[i] = lanes[i].fields;
                end
                to_drive_point();
            end
        end
        lane_valid = '0;
        repeat (8) to_drive_point();
        cfg_valid           = 1'b1;
        cfg_data.merge_mask = cfg_mask[t];
        cfg_data.ops_mask   = cfg_ops[t];
        stall_mode          = cfg_stall[t];
        to_drive_point();
        cfg_valid = 1'b0;
        cnt = 0;
        do begin
            @(posedge ap_clk);
            cnt++;
        end while (pending != 0 && cnt < wait_limit);
        if (pending != 0) report_timeout("end of expected output", t, wait_limit);
        cnt = 0;
        do begin
            @(posedge ap_clk);
            cnt++;
        end while (!done_out && cnt < done_limit);
        if (!done_out) report_timeout("done_out", t, done_limit);
        #2;
        // Settle so that any extra packet would still show up
        repeat (10) to_drive_point();
        stall_mode = 1'b0;
        test_end   = 1'b1;
        to_drive_point();
        test_end = 1'b0;
    endtask

    initial begin
        areset       = 1'b1;
        cfg_request  = 1'b0;
        cfg_valid    = 1'b0;
        cfg_data     = '0;
        lane_valid   = '0;
        lane_meta    = '0;
        lane_fields  = '0;
        exp_push     = 1'b0;
        exp_pkt      = '0;
        test_end     = 1'b0;
        test_num     = 0;
        stall_mode   = 1'b0;
        run_failures = 0;
        read_trace();
        foreach (test_list[k]) begin
            run_test(test_list[k]);
        end
        $display("Tests run: %0d, checker errors: %0d, run failures: %0d",
                 test_list.size(), err_count, run_failures);
        if (err_count == 0 && run_failures == 0 && test_list.size() > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_merge_data_generator

// File: bench/merge_checker.sv
// Merge output checker
// Compares every output packet with the expected packets in order,
// watches the setup strobe and the done flag, and reports each test

`timescale 1ns/1ps

module merge_checker (
    input  logic                                                          ap_clk,
    input  logic                                                          areset,
    input  logic                                                          cfg_valid,
    input  logic                                                          config_setup,
    input  logic                                                          done_out,
    input  logic [merge_packet_pkg::num_lanes-1:0]                        lane_full,
    input  logic                                                          out_valid,
    input  logic [merge_packet_pkg::meta_w-1:0]                           out_meta,
    input  logic [merge_packet_pkg::num_fields-1:0][merge_packet_pkg::field_w-1:0] out_fields,
    input  logic                                                          exp_push,
    input  merge_packet_pkg::packet_t                                     exp_pkt,
    input  logic                                                          test_end,
    input  int                                                            test_num,
    output int                                                            err_count,
    output int                                                            pending
);
    import merge_packet_pkg::*;

    packet_t exp_q [$];
    packet_t got;
    int      errs         = 0;
    int      test_errs    = 0;
    int      test_pkts    = 0;
    int      setup_pulses = 0;
    logic    cfg_seen     = 1'b0;

    initial begin
        err_count = 0;
        pending   = 0;
    end

    always @(posedge ap_clk) begin
        if (areset) begin
            cfg_seen = 1'b0;
        end else begin
            if (config_setup) begin
                setup_pulses++;
            end
            // Done must stay low until the configuration arrives
            if (!cfg_seen && done_out) begin
                $display("Error at %0t: done_out high before configuration in test %0d",
                         $time, test_num);
                errs++;
                test_errs++;
            end
            // Trace tests stay far below lane depth
            if (lane_full != '0) begin
                $display("Error at %0t: lane_full %b raised in test %0d",
                         $time, lane_full, test_num);
                errs++;
                test_errs++;
            end
            if (out_valid) begin
                got = {out_meta, out_fields};
                if (!cfg_seen) begin
                    $display("Error at %0t: output packet before configuration in test %0d",
                             $time, test_num);
                    errs++;
                    test_errs++;
                end
                if (exp_q.size() == 0) begin
                    $display("Unexpected output packet %h in test %0d at %0t",
                             got, test_num, $time);
                    errs++;
                    test_errs++;
                end else begin
                    if (got !== exp_q[0]) begin
                        $display("Error at %0t: test %0d packet %0d expected %h, got %h",
                                 $time, test_num, test_pkts, exp_q[0], got);
                        errs++;
                        test_errs++;
                    end
                    void'(exp_q.pop_front());
                    test_pkts++;
                end
            end
            if (cfg_valid) begin
                cfg_seen = 1'b1;
            end
            if (exp_push) begin
                exp_q.push_back(exp_pkt);
            end
            // ------------------------------------------------------------
            // End of test summary
            // ------------------------------------------------------------
            if (test_end) begin
                if (exp_q.size() != 0) begin
                    $display("Test %0d ended with %0d expected packets never received",
                             test_num, exp_q.size());
                    errs++;
                    test_errs++;
                    exp_q.delete();
                end
                if (setup_pulses != 1) begin
                    $display("config_setup pulsed %0d times in test %0d instead of once",
                             setup_pulses, test_num);
                    errs++;
                    test_errs++;
                end
                $display("Test %0d finished: %0d packets, %0d errors",
                         test_num, test_pkts, test_errs);
                test_errs    = 0;
                test_pkts    = 0;
                setup_pulses = 0;
            end
        end
        pending   <= exp_q.size();
        err_count <= errs;
    end

endmodule : merge_checker

// File: logic/merge_data_generator.sv
// Merge data generator, top level
// Registers lane inputs into per-lane FIFOs, merges masked lanes into
// one packet stream through an output FIFO, and reports done once the
// configured work has drained

`timescale 1ns/1ps

module merge_data_generator (
    input  logic                                                              ap_clk,
    input  logic                                                              areset,
    input  logic                                                              cfg_request,
    input  logic                                                              cfg_valid,
    input  merge_packet_pkg::merge_config_t                                   cfg_data,
    input  logic [merge_packet_pkg::num_lanes-1:0]                            lane_valid,
    input  logic [merge_packet_pkg::num_lanes-1:0][merge_packet_pkg::meta_w-1:0] lane_meta,
    input  logic [merge_packet_pkg::num_lanes-1:0][merge_packet_pkg::num_fields-1:0]
                 [merge_packet_pkg::field_w-1:0]                              lane_fields,
    output logic [merge_packet_pkg::num_lanes-1:0]                            lane_full,
    input  logic                                                              out_ready,
    output logic                                                              out_valid,
    output logic [merge_packet_pkg::meta_w-1:0]                               out_meta,
    output logic [merge_packet_pkg::num_fields-1:0][merge_packet_pkg::field_w-1:0] out_fields,
    output logic                                                              config_setup,
    output logic                                                              done_out
);
    import merge_packet_pkg::*;
    import merge_ctrl_pkg::*;

    logic                             areset_generator;
    logic [num_lanes-1:0]             lane_valid_q;
    packet_t [num_lanes-1:0]          lane_pkt_q;
    logic [num_lanes-1:0]             lane_empty;
    logic [num_lanes-1:0]             lane_pop;
    packet_t [num_lanes-1:0]          lane_head;
    logic                             config_valid;
    merge_config_t                    merge_config;
    logic                             done_flag;
    logic                             out_pop;
    packet_t                          out_head;

    merge_links_if links ();

    // ------------------------------------------------------------
    // Reset and input registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            lane_valid_q <= '0;
        end else begin
            lane_valid_q <= lane_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        for (int i = 0; i < num_lanes; i++) begin
            lane_pkt_q[i] <= {lane_meta[i], lane_fields[i]};
        end
    end

    // ------------------------------------------------------------
    // Lane FIFOs
    // ------------------------------------------------------------
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        // Flag one entry early, the input register may still hold a packet
        lane_fifo #(
            .pfull_level(fifo_depth - 1)
        ) u_lane_fifo (
            .ap_clk          (ap_clk),
            .areset_generator(areset_generator),
            .wr_en           (lane_valid_q[i]),
            .din             (lane_pkt_q[i]),
            .rd_en           (lane_pop[i]),
            .dout            (lane_head[i]),
            .empty           (lane_empty[i]),
            .full            (),
            .prog_full       (lane_full[i])
        );
    end

    merge_fsm u_fsm (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg_request     (cfg_request),
        .cfg_valid       (cfg_valid),
        .cfg_data        (cfg_data),
        .links           (links),
        .config_setup    (config_setup),
        .config_valid    (config_valid),
        .merge_config    (merge_config),
        .done_flag       (done_flag)
    );

    field_merger u_merger (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .config_valid    (config_valid),
        .merge_config    (merge_config),
        .lane_empty      (lane_empty),
        .lane_head       (lane_head),
        .lane_pop        (lane_pop),
        .links           (links)
    );

    // ------------------------------------------------------------
    // Output FIFO and output stage
    // ------------------------------------------------------------
    lane_fifo u_out_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (links.merge_wr),
        .din             (links.merge_pkt),
        .rd_en           (out_pop),
        .dout            (out_head),
        .empty           (links.out_empty),
        .full            (),
        .prog_full       (links.out_prog_full)
    );

    assign out_pop = ~links.out_empty & out_ready;

    // Unmasked lanes never drain, so only masked lanes count toward done
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_valid <= 1'b0;
            done_out  <= 1'b0;
        end else begin
            out_valid <= out_pop;
            done_out  <= done_flag & links.out_empty & ~links.merge_wr &
                         (&(lane_empty | ~merge_config.merge_mask));
        end
    end

    always_ff @(posedge ap_clk) begin
        if (out_pop) begin
            out_meta   <= out_head.meta;
            out_fields <= out_head.fields;
        end
    end

endmodule : merge_data_generator

// File: logic/field_merger.sv
// Field merger
// Pops all masked lanes in one cycle and builds the merged packet.
// Meta and default fields come from lane 0, ops bits pull field 0
// of a masked lane into the selected fields, higher lane wins

`timescale 1ns/1ps

module field_merger (
    input  logic                                                    ap_clk,
    input  logic                                                    areset_generator,
    input  logic                                                    config_valid,
    input  merge_packet_pkg::merge_config_t                         merge_config,
    input  logic [merge_packet_pkg::num_lanes-1:0]                  lane_empty,
    input  merge_packet_pkg::packet_t [merge_packet_pkg::num_lanes-1:0] lane_head,
    output logic [merge_packet_pkg::num_lanes-1:0]                  lane_pop,
    merge_links_if.merger                                           links
);
    import merge_packet_pkg::*;

    logic    pop_ok;
    packet_t merged;

    // Joint pop once every masked lane holds a packet
    assign pop_ok = config_valid & ~links.out_prog_full &
                    ((~lane_empty & merge_config.merge_mask) == merge_config.merge_mask);
    assign lane_pop = pop_ok ? merge_config.merge_mask : '0;

    // Ascending lane order lets the higher lane win a field
    always_comb begin
        merged = lane_head[0];
        for (int i = 0; i < num_lanes; i++) begin
            for (int j = 0; j < num_fields; j++) begin
                if (merge_config.merge_mask[i] && merge_config.ops_mask[i][j]) begin
                    merged.fields[j] = lane_head[i].fields[0];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Merge register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            links.merge_wr <= 1'b0;
        end else begin
            links.merge_wr <= pop_ok;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop_ok) begin
            links.merge_pkt <= merged;
        end
    end

    // Pops stay on the lanes of the configuration in force while merging runs
    a_config_stable : assert property (@(posedge ap_clk) disable iff (areset_generator)
        (config_valid && $past(config_valid)) |-> $stable(merge_config))
        else $error("merge configuration changed while merging");

endmodule : field_merger

// File: logic/merge_fsm.sv
// Merge control FSM
// Waits for a setup request, pulses config_setup, captures the
// merge configuration and then runs, pausing while the output FIFO
// sits above its threshold

`timescale 1ns/1ps

module merge_fsm (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  logic                            cfg_request,
    input  logic                            cfg_valid,
    input  merge_packet_pkg::merge_config_t cfg_data,
    merge_links_if.fsm                      links,
    output logic                            config_setup,
    output logic                            config_valid,
    output merge_packet_pkg::merge_config_t merge_config,
    output logic                            done_flag
);
    import merge_ctrl_pkg::*;

    merge_state_t state;
    merge_state_t next_state;
    logic         cfg_captured;

    // ------------------------------------------------------------
    // State register and next state
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET:       next_state = IDLE;
            IDLE:        next_state = SETUP_IDLE;
            SETUP_IDLE:  next_state = cfg_request ? SETUP_TRANS : SETUP_IDLE;
            SETUP_TRANS: next_state = SETUP;
            SETUP:       next_state = cfg_valid ? START : SETUP;
            START:       next_state = BUSY;
            BUSY:        next_state = links.out_prog_full ? PAUSE : BUSY;
            PAUSE:       next_state = links.out_prog_full ? PAUSE : BUSY;
            default:     next_state = RESET;
        endcase
    end

    // ------------------------------------------------------------
    // Setup strobe and configuration capture
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_setup <= 1'b0;
            cfg_captured <= 1'b0;
        end else begin
            // One cycle pulse, SETUP_TRANS lasts a single cycle
            config_setup <= (state == SETUP_TRANS);
            if (state == SETUP && cfg_valid) begin
                cfg_captured <= 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (state == SETUP && cfg_valid) begin
            merge_config <= cfg_data;
        end
    end

    // Merging only runs in BUSY
    assign config_valid = cfg_captured & (state == BUSY);
    assign done_flag    = (state == START) | (state == BUSY) | (state == PAUSE);

    // Lane 0 supplies meta, so it must take part in every merge
    a_lane0_masked : assert property (@(posedge ap_clk) disable iff (areset_generator)
        $rose(cfg_captured) |-> merge_config.merge_mask[0])
        else $error("merge mask captured without lane 0");

endmodule : merge_fsm

// File: logic/lane_fifo.sv
// Lane FIFO
// Small synchronous first-word-fall-through FIFO for packets.
// Keeps a fill count and raises prog_full at a programmable level

`timescale 1ns/1ps

module lane_fifo #(
    parameter int pfull_level = merge_ctrl_pkg::prog_thresh
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      wr_en,
    input  merge_packet_pkg::packet_t din,
    input  logic                      rd_en,
    output merge_packet_pkg::packet_t dout,
    output logic                      empty,
    output logic                      full,
    output logic                      prog_full
);
    import merge_packet_pkg::*;
    import merge_ctrl_pkg::*;

    packet_t                         mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(fifo_depth)-1:0]   rd_ptr;
    logic [fill_w-1:0]               count;

    // ------------------------------------------------------------
    // Pointers and fill count
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fill_w'(wr_en) - fill_w'(rd_en);
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head shows through while not empty
    assign dout      = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == fill_w'(fifo_depth));
    assign prog_full = (count >= fill_w'(pfull_level));

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_no_overflow : assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(wr_en && full))
        else $error("lane_fifo write while full");

    a_no_underflow : assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(rd_en && empty))
        else $error("lane_fifo read while empty");

endmodule : lane_fifo

// File: logic/merge_links_if.sv
// Links between the field merger, the output FIFO and the control FSM
// Merged packets flow to the FIFO, fill status flows back

`timescale 1ns/1ps

interface merge_links_if;
    import merge_packet_pkg::*;

    logic    merge_wr;
    packet_t merge_pkt;
    logic    out_prog_full;
    logic    out_empty;

    modport merger (output merge_wr, output merge_pkt, input out_prog_full);

    modport out_fifo (
        input  merge_wr,
        input  merge_pkt,
        output out_prog_full,
        output out_empty
    );

    modport fsm (input out_prog_full);

endinterface : merge_links_if

// File: logic/merge_ctrl_pkg.sv
// Merge data generator control definitions
// FIFO sizing, programmable-full level and the control FSM states

package merge_ctrl_pkg;

    localparam int fifo_depth  = 16;
    localparam int prog_thresh = 8;
    // Holds 0 to fifo_depth
    localparam int fill_w      = 5;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        SETUP_IDLE,
        SETUP_TRANS,
        SETUP,
        START,
        BUSY,
        PAUSE
    } merge_state_t;

endpackage : merge_ctrl_pkg

// File: logic/merge_packet_pkg.sv
// Merge data generator packet definitions
// Lane and field geometry, the packet layout carried on every lane
// and the configuration word that selects lanes and field operations

package merge_packet_pkg;

    // ------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------
    localparam int num_lanes  = 4;
    localparam int num_fields = 4;
    localparam int field_w    = 16;
    localparam int meta_w     = 8;

    // ------------------------------------------------------------
    // Packet and configuration types
    // ------------------------------------------------------------
    // 8 bit meta on top, field 0 in the low bits
    typedef struct packed {
        logic [meta_w-1:0]                   meta;
        logic [num_fields-1:0][field_w-1:0] fields;
    } packet_t;

    // ops_mask[i][j] set means field j takes field 0 of lane i
    typedef struct packed {
        logic [num_lanes-1:0]                  merge_mask;
        logic [num_lanes-1:0][num_fields-1:0] ops_mask;
    } merge_config_t;

endpackage : merge_packet_pkg
